// ==== hw/flash_consts.svh ====
`ifndef FLASH_CONSTS_SVH
`define FLASH_CONSTS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////
`define FLASH_ADDR_W 23
`define FLASH_DATA_W 16

//////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////
`define FLASH_BLOCK_SIZE   23'h010000 // 64K words
`define FLASH_ERASE_LAST   23'h030000 // Init erases blocks 0 to 3
`define FLASH_LAST_ADDRESS 23'h7FFFFF

//////////////////////////////////////////////////
// Command register codes
//////////////////////////////////////////////////
`define CMD_READ_ID     16'h0090
`define CMD_READ_ARRAY  16'h00FF
`define CMD_CLEAR_LOCKS 16'h0060
`define CMD_CONFIRM     16'h00D0 // Second cycle of lock clear and erase
`define CMD_ERASE       16'h0020
`define CMD_SETUP_WRITE 16'h0040

// Device ID codes
`define ID_MANUFACTURER 16'h0089 // Read at address 0
`define ID_SIZE         16'h0018 // 128 Mbit part

`endif

// ==== hw/flash_pkg.sv ====
`default_nettype none

`include "flash_consts.svh"

package flash_pkg;

   // Operation on the flash bus
   typedef enum logic [1:0] {
      op_idle  = 2'b00,
      op_read  = 2'b01,
      op_write = 2'b10
   } flash_op_e;

   typedef enum logic [2:0] {
      act_hold,
      act_clear,
      act_set_one,    // Device size code location
      act_load,       // Take addrin
      act_next_block,
      act_next_word
   } addr_action_e;

   typedef struct packed {
      logic [7:0] unused;
      logic       ready;    // Write state machine idle
      logic [5:0] error;
      logic       reserved;
   } flash_status_s;

   // Read word seen as raw data (ID codes) or as status register
   typedef union packed {
      logic [`FLASH_DATA_W-1:0] raw;
      flash_status_s            sr;
   } flash_word_u;

endpackage

`default_nettype wire

// ==== hw/tester_pkg.sv ====
`default_nettype none

package tester_pkg;

   typedef enum logic [1:0] {
      mode_idle  = 2'd0,
      mode_init  = 2'd1,
      mode_write = 2'd2,
      mode_read  = 2'd3
   } mode_e;

   // Codes 6 and C are not used by this tester
   typedef enum logic [3:0] {
      status_reset            = 4'h0,
      status_read_id          = 4'h1,
      status_clear_locks      = 4'h2,
      status_erasing          = 4'h3,
      status_writing          = 4'h4,
      status_reading          = 4'h5,
      status_bad_manufacturer = 4'h7,
      status_bad_size         = 4'h8,
      status_lock_error       = 4'h9,
      status_erase_error      = 4'hA,
      status_write_error      = 4'hB
   } status_e;

endpackage

`default_nettype wire

// ==== hw/flash_step_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_consts.svh"

interface flash_step_if
   import flash_pkg::*;
();

   // Driver to sequencer
   logic step;                // Flash free and no operation pending
   logic ready;
   logic error;
   logic id_manufacturer_ok;
   logic id_size_ok;
   logic at_erase_last;
   logic at_last_address;

   // Sequencer to driver, taken on step cycles only
   flash_op_e                op;
   addr_action_e             action;
   logic [`FLASH_DATA_W-1:0] wdata;

   modport seq (
      input  step, ready, error, id_manufacturer_ok, id_size_ok,
      input  at_erase_last, at_last_address,
      output op, action, wdata
   );

   modport drv (
      output step, ready, error, id_manufacturer_ok, id_size_ok,
      output at_erase_last, at_last_address,
      input  op, action, wdata
   );

endinterface

`default_nettype wire

// ==== hw/flash_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_consts.svh"

module flash_sequencer
   import flash_pkg::*;
   import tester_pkg::*;
(
   input  logic                     clock,
   input  logic                     reset,
   input  mode_e                    mode,
   input  logic [`FLASH_DATA_W-1:0] datain,
   output logic                     busy,
   output status_e                  status,
   flash_step_if.seq                sif
);

   typedef enum logic [4:0] {
      st_home,
      st_id_cmd, st_id_mfr, st_id_check_mfr, st_id_check_size,
      st_lock_cmd, st_lock_confirm, st_lock_status, st_lock_poll,
      st_erase_cmd, st_erase_confirm, st_erase_status, st_erase_poll,
      st_write_setup, st_write_data, st_write_status, st_write_poll,
      st_read_init, st_read
   } state_e;

   state_e                   state;
   state_e                   state_next;
   status_e                  status_next;
   logic                     busy_next;
   logic [`FLASH_DATA_W-1:0] data_to_store;

   always_comb
   begin
      state_next  = state;
      status_next = status;
      busy_next   = busy;
      sif.op      = op_idle;
      sif.action  = act_hold;
      sif.wdata   = data_to_store;
      case (state)
         st_home:
            case (mode)
               mode_init:
               begin
                  state_next = st_id_cmd;
                  busy_next  = 1'b1;
               end
               mode_write:
               begin
                  state_next = st_write_setup;
                  busy_next  = 1'b1;
               end
               mode_read:
               begin
                  busy_next  = 1'b1;
                  // Array mode already set by an earlier read
                  state_next = (status == status_reading) ? st_read : st_read_init;
               end
               default:
                  busy_next = 1'b0;
            endcase

         //////////////////////////////////////////////////
         // Init: ID check and lock clear
         //////////////////////////////////////////////////
         st_id_cmd:
         begin
            status_next = status_read_id;
            sif.op      = op_write;
            sif.action  = act_clear;
            sif.wdata   = `CMD_READ_ID;
            state_next  = st_id_mfr;
         end
         st_id_mfr:
         begin
            sif.op     = op_read;
            sif.action = act_clear;
            state_next = st_id_check_mfr;
         end
         st_id_check_mfr:
            if (!sif.id_manufacturer_ok)
               status_next = status_bad_manufacturer;
            else
            begin
               sif.op     = op_read;
               sif.action = act_set_one; // Size code lives at 1
               state_next = st_id_check_size;
            end
         st_id_check_size:
            if (!sif.id_size_ok)
               status_next = status_bad_size;
            else
            begin
               sif.op     = op_write;
               sif.action = act_clear;
               sif.wdata  = `CMD_READ_ARRAY;
               state_next = st_lock_cmd;
            end
         st_lock_cmd:
         begin
            status_next = status_clear_locks;
            sif.op      = op_write;
            sif.action  = act_clear;
            sif.wdata   = `CMD_CLEAR_LOCKS;
            state_next  = st_lock_confirm;
         end
         st_lock_confirm:
         begin
            sif.op     = op_write;
            sif.action = act_clear;
            sif.wdata  = `CMD_CONFIRM;
            state_next = st_lock_status;
         end
         st_lock_status:
         begin
            sif.op     = op_read;
            sif.action = act_clear;
            state_next = st_lock_poll;
         end
         st_lock_poll:
            if (!sif.ready)
            begin
               sif.op     = op_read; // Still clearing, poll again
               sif.action = act_clear;
            end
            else if (sif.error)
               status_next = status_lock_error;
            else
            begin
               sif.action = act_clear;
               state_next = st_erase_cmd;
            end

         //////////////////////////////////////////////////
         // Block erase
         //////////////////////////////////////////////////
         st_erase_cmd:
         begin
            status_next = status_erasing;
            sif.op      = op_write;
            sif.wdata   = `CMD_ERASE;
            state_next  = st_erase_confirm;
         end
         st_erase_confirm:
         begin
            sif.op     = op_write;
            sif.wdata  = `CMD_CONFIRM;
            state_next = st_erase_status;
         end
         st_erase_status:
         begin
            sif.op     = op_read;
            state_next = st_erase_poll;
         end
         st_erase_poll:
            if (!sif.ready)
               sif.op = op_read;
            else if (sif.error)
               status_next = status_erase_error;
            else if (!sif.at_erase_last)
            begin
               sif.action = act_next_block;
               state_next = st_erase_cmd;
            end
            else
            begin
               sif.action = act_clear; // All blocks done
               state_next = st_home;
            end

         //////////////////////////////////////////////////
         // Word write
         //////////////////////////////////////////////////
         st_write_setup:
         begin
            status_next = status_writing;
            sif.op      = op_write;
            sif.wdata   = `CMD_SETUP_WRITE;
            state_next  = st_write_data;
         end
         st_write_data:
         begin
            sif.op     = op_write; // Latched word
            state_next = st_write_status;
         end
         st_write_status:
         begin
            sif.op     = op_read;
            state_next = st_write_poll;
         end
         st_write_poll:
            if (!sif.ready)
               sif.op = op_read;
            else if (sif.error || sif.at_last_address)
               status_next = status_write_error; // Top of array counts as error
            else
            begin
               sif.action = act_next_word;
               state_next = st_home;
            end

         //////////////////////////////////////////////////
         // Read
         //////////////////////////////////////////////////
         st_read_init:
         begin
            status_next = status_reading;
            sif.op      = op_write;
            sif.action  = act_clear;
            sif.wdata   = `CMD_READ_ARRAY;
            state_next  = st_read;
         end
         st_read:
         begin
            sif.op     = op_read;
            sif.action = act_load;
            state_next = st_home;
         end
         default:
            state_next = st_home;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state  <= st_home;
         status <= status_reset;
         busy   <= 1'b1;
      end
      else if (sif.step)
      begin
         state  <= state_next;
         status <= status_next;
         busy   <= busy_next;
      end
   end

   always_ff @(posedge clock)
   begin
      if (sif.step && (state == st_write_setup))
         data_to_store <= datain; // Sampled with the setup command
   end

   // Busy drops only while parked at home
   assert property (@(posedge clock) disable iff (reset)
      (state != st_home) |-> busy);

endmodule

`default_nettype wire

// ==== hw/flash_bus_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_consts.svh"

module flash_bus_driver
   import flash_pkg::*;
(
   input  logic                     clock,
   input  logic                     reset,
   input  logic [`FLASH_ADDR_W-1:0] addrin,
   input  logic [`FLASH_DATA_W-1:0] frdata,
   input  logic                     fbusy,
   output flash_op_e                fop,
   output logic [`FLASH_ADDR_W-1:0] faddress,
   output logic [`FLASH_DATA_W-1:0] fwdata,
   flash_step_if.drv                sif
);

   localparam logic [`FLASH_ADDR_W-1:0] addr_one = {{(`FLASH_ADDR_W-1){1'b0}}, 1'b1};

   flash_word_u rword;

   //////////////////////////////////////////////////
   // Step gate and read data decode
   //////////////////////////////////////////////////
   assign sif.step = !fbusy && (fop == op_idle);

   assign rword.raw = frdata;
   assign sif.ready = rword.sr.ready;
   assign sif.error = |rword.sr.error; // Any of the six error bits

   assign sif.id_manufacturer_ok = (rword.raw == `ID_MANUFACTURER);
   assign sif.id_size_ok         = (rword.raw == `ID_SIZE);

   assign sif.at_erase_last   = (faddress == `FLASH_ERASE_LAST);
   assign sif.at_last_address = (faddress == `FLASH_LAST_ADDRESS);

   //////////////////////////////////////////////////
   // Operation and address registers
   //////////////////////////////////////////////////
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         fop      <= op_idle;
         faddress <= '0;
      end
      else if (sif.step)
      begin
         fop <= sif.op;
         case (sif.action)
            act_clear:      faddress <= '0;
            act_set_one:    faddress <= addr_one;
            act_load:       faddress <= addrin;
            act_next_block: faddress <= faddress + `FLASH_BLOCK_SIZE;
            act_next_word:  faddress <= faddress + addr_one;
            default:        faddress <= faddress;
         endcase
      end
      else
         fop <= op_idle; // One-cycle pulse
   end

   always_ff @(posedge clock)
   begin
      if (sif.step && (sif.op == op_write))
         fwdata <= sif.wdata;
   end

   // Every issued operation is a single-cycle pulse
   assert property (@(posedge clock) disable iff (reset)
      (fop != op_idle) |=> (fop == op_idle));

   // Word increment never wraps past the top of the array
   assert property (@(posedge clock) disable iff (reset)
      (sif.step && (sif.action == act_next_word)) |-> !sif.at_last_address);

endmodule

`default_nettype wire

// ==== hw/flash_tester.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_consts.svh"

module flash_tester
   import flash_pkg::*;
   import tester_pkg::*;
(
   input  logic                     clock,
   input  logic                     reset,
   input  mode_e                    mode,
   input  logic [`FLASH_DATA_W-1:0] datain,
   input  logic [`FLASH_ADDR_W-1:0] addrin,
   input  logic [`FLASH_DATA_W-1:0] frdata,
   input  logic                     fbusy,
   output flash_op_e                fop,
   output logic [`FLASH_ADDR_W-1:0] faddress,
   output logic [`FLASH_DATA_W-1:0] fwdata,
   output logic                     busy,
   output status_e                  status
);

   flash_step_if sif ();

   // Command sequences
   flash_sequencer u_sequencer (
      .clock  (clock),
      .reset  (reset),
      .mode   (mode),
      .datain (datain),
      .busy   (busy),
      .status (status),
      .sif    (sif.seq)
   );

   // Flash bus registers and step gate
   flash_bus_driver u_driver (
      .clock    (clock),
      .reset    (reset),
      .addrin   (addrin),
      .frdata   (frdata),
      .fbusy    (fbusy),
      .fop      (fop),
      .faddress (faddress),
      .fwdata   (fwdata),
      .sif      (sif.drv)
   );

endmodule

`default_nettype wire

// ==== verif/tb_flash_tester.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_consts.svh"

module tb_flash_tester
   import flash_pkg::*;
   import tester_pkg::*;
();

   localparam int cycles_per_record = 300; // Worst case is a full init with slow polls
   localparam int max_records       = 64;

   logic                     clock;
   logic                     reset;
   mode_e                    mode;
   logic [`FLASH_DATA_W-1:0] datain;
   logic [`FLASH_ADDR_W-1:0] addrin;
   logic [`FLASH_DATA_W-1:0] frdata;
   logic                     fbusy;
   flash_op_e                fop;
   logic [`FLASH_ADDR_W-1:0] faddress;
   logic [`FLASH_DATA_W-1:0] fwdata;
   logic                     busy;
   status_e                  status;

   // Flash model state
   logic [7:0]               lfsr_state;
   int                       busy_left;
   int                       polls_left;
   logic                     id_mode;
   logic                     status_mode;
   logic                     expect_data;  // Word after setup-write
   logic [15:0]              group_cmd;
   logic [15:0]              rec_mfr;
   logic [15:0]              rec_size;
   logic [15:0]              rec_err_cmd;
   logic [5:0]               rec_err;
   logic [`FLASH_ADDR_W-1:0] last_read_addr;
   logic [`FLASH_ADDR_W-1:0] log_addr[$];
   logic [`FLASH_DATA_W-1:0] log_data[$];

   // Expected state, built from the command rules
   logic [`FLASH_ADDR_W-1:0] exp_addr[$];
   logic [`FLASH_DATA_W-1:0] exp_data[$];
   logic [`FLASH_ADDR_W-1:0] cur_addr;
   logic                     array_mode;
   status_e                  cur_status;

   logic [31:0]              recs[max_records][10];
   int                       num_records;
   int                       cycle_count;
   int                       cycle_limit;

   flash_tester UUT (
      .clock    (clock),
      .reset    (reset),
      .mode     (mode),
      .datain   (datain),
      .addrin   (addrin),
      .frdata   (frdata),
      .fbusy    (fbusy),
      .fop      (fop),
      .faddress (faddress),
      .fwdata   (fwdata),
      .busy     (busy),
      .status   (status)
   );

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
         abort_run($sformatf("mismatch at %0d ns: %s, got %h, expected %h",
            $time, what, got, exp));
   endtask

   // Galois LFSR, one step per bit taken
   function automatic int random_bits(input int n);
      int value;
      value = 0;
      for (int b = 0; b < n; b++)
      begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 8'hB8) : (lfsr_state >> 1);
         value      = (value << 1) | int'(lfsr_state[0]);
      end
      return value;
   endfunction

   task automatic next_cycle();
      @(posedge clock);
      #1;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (5) next_cycle();
      reset      = 1'b0;
      cur_addr   = '0;
      array_mode = 1'b0;
      cur_status = status_reset;
   endtask

   task automatic push_write(input logic [`FLASH_ADDR_W-1:0] a, input logic [15:0] d);
      exp_addr.push_back(a);
      exp_data.push_back(d);
   endtask

   //////////////////////////////////////////////////
   // Flash model
   //////////////////////////////////////////////////
   task automatic respond_to_pulse();
      flash_word_u word;
      word.raw = '0;
      if (fop == op_write)
      begin
         log_addr.push_back(faddress);
         log_data.push_back(fwdata);
         if (expect_data)
            expect_data = 1'b0;
         else
            case (fwdata)
               `CMD_READ_ID:
               begin
                  id_mode     = 1'b1;
                  status_mode = 1'b0;
               end
               `CMD_READ_ARRAY:
               begin
                  id_mode     = 1'b0;
                  status_mode = 1'b0;
               end
               `CMD_CONFIRM:
                  status_mode = 1'b1;
               default:
               begin
                  // Lock clear, erase or setup-write opens a new operation
                  group_cmd   = fwdata;
                  id_mode     = 1'b0;
                  status_mode = 1'b1;
                  polls_left  = random_bits(2);
                  expect_data = (fwdata == `CMD_SETUP_WRITE);
               end
            endcase
      end
      else
      begin
         last_read_addr = faddress;
         if (id_mode)
            word.raw = (faddress == 23'd0) ? rec_mfr : ((faddress == 23'd1) ? rec_size : 16'h0);
         else if (status_mode)
         begin
            if (polls_left > 0)
               polls_left--; // Not ready yet
            else
            begin
               word.sr.ready = 1'b1;
               if (group_cmd == rec_err_cmd)
                  word.sr.error = rec_err;
            end
         end
         else
            word.raw = faddress[15:0] ^ 16'h5A5A; // Array data
         frdata = word.raw;
      end
   endtask

   always @(posedge clock)
   begin
      #1;
      if (reset)
      begin
         fbusy       = 1'b0;
         busy_left   = 0;
         polls_left  = 0;
         id_mode     = 1'b0;
         status_mode = 1'b0;
         expect_data = 1'b0;
      end
      else
      begin
         if (busy_left > 0)
            busy_left--;
         if (fop != op_idle)
         begin
            respond_to_pulse();
            busy_left = random_bits(2); // 0 to 3 busy cycles
         end
         fbusy = (busy_left > 0);
      end
   end

   always @(posedge clock)
   begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
         abort_run($sformatf("timeout: the run did not end within %0d cycles", cycle_limit));
   end

   //////////////////////////////////////////////////
   // One stim record
   //////////////////////////////////////////////////
   task automatic run_record(input int i);
      mode_e                    rec_mode;
      status_e                  want_status;
      logic [`FLASH_ADDR_W-1:0] want_addr;
      logic                     failed;
      int                       waited;
      rec_mode    = mode_e'(recs[i][0][1:0]);
      rec_mfr     = recs[i][3][15:0];
      rec_size    = recs[i][4][15:0];
      rec_err_cmd = recs[i][5][15:0];
      rec_err     = recs[i][6][5:0];
      want_status = cur_status;
      want_addr   = cur_addr;
      failed      = 1'b0;
      exp_addr.delete();
      exp_data.delete();
      case (rec_mode)
         mode_init:
         begin
            push_write('0, `CMD_READ_ID);
            want_addr = '0;
            if (rec_mfr != `ID_MANUFACTURER)
               want_status = status_bad_manufacturer;
            else if (rec_size != `ID_SIZE)
            begin
               want_status = status_bad_size;
               want_addr   = 23'd1;
            end
            else
            begin
               push_write('0, `CMD_READ_ARRAY);
               push_write('0, `CMD_CLEAR_LOCKS);
               push_write('0, `CMD_CONFIRM);
               want_status = status_erasing;
               if (rec_err_cmd == `CMD_CLEAR_LOCKS && rec_err != 0)
                  want_status = status_lock_error;
               else
                  for (int b = 0; b < 4 && !failed; b++)
                  begin
                     push_write(b * `FLASH_BLOCK_SIZE, `CMD_ERASE);
                     push_write(b * `FLASH_BLOCK_SIZE, `CMD_CONFIRM);
                     if (rec_err_cmd == `CMD_ERASE && rec_err != 0)
                     begin
                        want_status = status_erase_error;
                        want_addr   = b * `FLASH_BLOCK_SIZE;
                        failed      = 1'b1;
                     end
                  end
            end
         end
         mode_write:
         begin
            push_write(cur_addr, `CMD_SETUP_WRITE);
            push_write(cur_addr, recs[i][1][15:0]);
            if ((rec_err_cmd == `CMD_SETUP_WRITE && rec_err != 0) ||
                cur_addr == `FLASH_LAST_ADDRESS)
               want_status = status_write_error;
            else
            begin
               want_status = status_writing;
               want_addr   = cur_addr + 23'd1;
            end
         end
         mode_read:
         begin
            if (!array_mode)
               push_write('0, `CMD_READ_ARRAY);
            want_status = status_reading;
            want_addr   = recs[i][2][22:0];
         end
         default:
            want_status = cur_status;
      endcase

      log_addr.delete();
      log_data.delete();
      datain = recs[i][1][15:0];
      addrin = recs[i][2][22:0];
      mode   = rec_mode;
      if (rec_mode != mode_idle)
      begin
         waited = 0;
         while (fop == op_idle)
         begin
            next_cycle();
            waited++;
            if (waited > cycles_per_record)
               abort_run($sformatf("record %0d started no flash operation", i));
         end
         mode = mode_idle; // Run the mode once
      end

      waited = 0;
      while (busy && status < status_bad_manufacturer)
      begin
         next_cycle();
         waited++;
         if (waited > cycles_per_record)
            abort_run($sformatf("record %0d: busy did not fall in time", i));
      end
      if (!busy)
         repeat (3) next_cycle();
      else
         repeat (20) next_cycle(); // Error state must stay quiet

      check_value(status, want_status, $sformatf("record %0d status", i));
      check_value(status, recs[i][7], $sformatf("record %0d status from stim", i));
      check_value(faddress, want_addr, $sformatf("record %0d faddress", i));
      check_value(faddress, recs[i][8], $sformatf("record %0d faddress from stim", i));
      check_value(!busy, recs[i][9], $sformatf("record %0d busy low", i));
      check_value(fop, op_idle, $sformatf("record %0d fop at end", i));
      check_value(log_addr.size(), exp_addr.size(), $sformatf("record %0d write count", i));
      for (int k = 0; k < exp_addr.size(); k++)
      begin
         check_value(log_addr[k], exp_addr[k], $sformatf("record %0d write %0d address", i, k));
         check_value(log_data[k], exp_data[k], $sformatf("record %0d write %0d data", i, k));
      end
      if (rec_mode == mode_read)
         check_value(last_read_addr, want_addr, $sformatf("record %0d read address", i));

      cur_addr   = want_addr;
      cur_status = want_status;
      array_mode = (want_status == status_reading);
      if (want_status >= status_bad_manufacturer)
         apply_reset(); // Only reset leaves an error state
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial
   begin
      int    fd;
      string line;
      reset       = 1'b1;
      mode        = mode_idle;
      datain      = '0;
      addrin      = '0;
      frdata      = '0;
      fbusy       = 1'b0;
      lfsr_state  = 8'd8;
      cycle_count = 0;
      cycle_limit = 0;
      num_records = 0;

      fd = $fopen("verif/flash_stim.txt", "r");
      if (fd == 0)
         abort_run("cannot open verif/flash_stim.txt");
      while ($fgets(line, fd) > 0)
      begin
         if (line.len() < 5 || line.getc(0) == 8'h23)
            continue; // Comment or blank
         if (num_records < max_records)
         begin
            void'($sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
               recs[num_records][0], recs[num_records][1], recs[num_records][2],
               recs[num_records][3], recs[num_records][4], recs[num_records][5],
               recs[num_records][6], recs[num_records][7], recs[num_records][8],
               recs[num_records][9]));
            num_records++;
         end
      end
      $fclose(fd);
      if (num_records == 0)
         abort_run("the stim file holds no records");
      cycle_limit = (num_records + 1) * cycles_per_record;

      apply_reset();
      check_value(fop, op_idle, "fop after reset");
      check_value(faddress, 23'd0, "faddress after reset");
      check_value(busy, 1'b1, "busy after reset");
      check_value(status, status_reset, "status after reset");

      for (int i = 0; i < num_records; i++)
         run_record(i);

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flash_tester.f ====
+incdir+hw
hw/flash_pkg.sv
hw/tester_pkg.sv
hw/flash_step_if.sv
hw/flash_sequencer.sv
hw/flash_bus_driver.sv
hw/flash_tester.sv
verif/tb_flash_tester.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the flash tester testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flash_tester.f \
   --top-module tb_flash_tester -o Vtb_flash_tester

output=$(./obj_dir/Vtb_flash_tester 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1

// ==== verif/flash_stim.txt ====
# mode datain addrin mfr size err_cmd err exp_status exp_addr busy_low (all hex)
# mode 0 idle, 1 init, 2 write, 3 read; err applies to status reads after err_cmd
1 0000 000000 0089 0018 00 00 3 000000 1
2 1234 000000 0089 0018 00 00 4 000001 1
2 BEEF 000000 0089 0018 00 00 4 000002 1
3 0000 000100 0089 0018 00 00 5 000100 1
3 0000 000200 0089 0018 00 00 5 000200 1
2 CAFE 000000 0089 0018 00 00 4 000201 1
3 0000 7FFFFF 0089 0018 00 00 5 7FFFFF 1
2 5555 000000 0089 0018 00 00 B 7FFFFF 0
2 0F0F 000000 0089 0018 40 02 B 000000 0
1 0000 000000 0088 0018 00 00 7 000000 0
1 0000 000000 0089 0017 00 00 8 000001 0
1 0000 000000 0089 0018 60 10 9 000000 0
1 0000 000000 0089 0018 20 04 A 000000 0
0 0000 000000 0089 0018 00 00 0 000000 1
1 0000 000000 0089 0018 00 00 3 000000 1
3 0000 000042 0089 0018 00 00 5 000042 1
2 00FF 000000 0089 0018 00 00 4 000043 1
